// ==== verilog/div_pkg.sv ====
`default_nettype none

package div_pkg;

    localparam int XLEN = 32;

    // data word and the widths derived from it
    typedef logic [XLEN-1:0] word_t;

    // top bit set means the dividend is below the divisor
    typedef logic [5:0] shift_t;

    typedef logic [4:0] bitpos_t;

    // pipeline operation fields
    typedef logic [3:0] op_class_t;
    typedef logic [4:0] div_op_t;

    localparam op_class_t OP_CLASS_DIV = 4'd2;

    localparam div_op_t DIV_S = 5'd0;
    localparam div_op_t REM_S = 5'd1;
    localparam div_op_t DIV_U = 5'd2;
    localparam div_op_t REM_U = 5'd3;

    // divider sequencing
    typedef enum logic [1:0] {
        S_IDLE,
        S_ALIGN,
        S_ITER,
        S_FIX
    } div_state_t;

endpackage

`default_nettype wire

// ==== verilog/msb_locator.sv ====
`timescale 1ns/1ps
`default_nettype none

module msb_locator
    import div_pkg::*;
(
    input  wire word_t din,
    output bitpos_t    pos
);

    logic [15:0] d16;
    logic [7:0]  d8;
    logic [3:0]  d4;
    logic [1:0]  d2;
    logic        hi16;
    logic        hi8;
    logic        hi4;
    logic        hi2;

    // binary search, each level keeps the half holding the leading one
    always_comb
    begin
        hi16 = |din[31:16];
        d16 = hi16 ? din[31:16] : din[15:0];

        hi8 = |d16[15:8];
        d8 = hi8 ? d16[15:8] : d16[7:0];

        hi4 = |d8[7:4];
        d4 = hi4 ? d8[7:4] : d8[3:0];

        hi2 = |d4[3:2];
        d2 = hi2 ? d4[3:2] : d4[1:0];
    end

    // zero input falls through to position 0
    assign pos = {hi16, hi8, hi4, hi2, d2[1]};

endmodule

`default_nettype wire

// ==== verilog/div_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_issue
    import div_pkg::*;
(
    input  wire            clk,
    input  wire            reset,
    input  wire            flush1,
    input  wire            flush2,
    input  wire            stall2,
    input  wire            core_idle,
    input  wire op_class_t op_class,
    input  wire div_op_t   op_sub,
    input  wire word_t     din1,
    input  wire word_t     din2,
    output logic           start,
    output word_t          a_mag,
    output word_t          b_mag,
    output logic           neg_q,
    output logic           neg_r,
    output logic           sel_rem,
    output logic           div_zero
);

    logic accept;
    logic is_signed;
    logic is_rem;
    logic sign_a;
    logic sign_b;

    always_comb
    begin
        is_signed = 1'b0;
        is_rem = 1'b0;
        case (op_sub)
            DIV_S:
            begin
                is_signed = 1'b1;
            end
            REM_S:
            begin
                is_signed = 1'b1;
                is_rem = 1'b1;
            end
            DIV_U:
            begin
                is_rem = 1'b0;
            end
            REM_U:
            begin
                is_rem = 1'b1;
            end
            // unknown subtypes run as unsigned divide
            default:
            begin
                is_rem = 1'b0;
            end
        endcase
    end

    assign accept = (op_class == OP_CLASS_DIV) && !flush1 && !stall2 && core_idle;

    // signs only count for the signed subtypes
    assign sign_a = is_signed & din1[XLEN-1];
    assign sign_b = is_signed & din2[XLEN-1];

    always_ff @(posedge clk)
    begin
        if (reset || flush2)
            start <= 1'b0;
        else
            start <= accept;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            a_mag <= sign_a ? word_t'(-din1) : din1;
            b_mag <= sign_b ? word_t'(-din2) : din2;
            neg_q <= sign_a ^ sign_b;
            neg_r <= sign_a;
            sel_rem <= is_rem;
            div_zero <= (din2 == '0);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/div_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_core
    import div_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        flush2,
    input  wire        start,
    input  wire word_t a_mag,
    input  wire word_t b_mag,
    input  wire        neg_q,
    input  wire        neg_r,
    input  wire        div_zero,
    output logic       idle,
    output logic       fin,
    output word_t      quo,
    output word_t      rem
);

    div_state_t state;

    // partial remainder and quotient under construction
    word_t part_rem;
    word_t q;

    shift_t cnt;
    shift_t shift;

    bitpos_t rem_pos;
    bitpos_t div_pos;

    logic [XLEN:0] trial;
    logic          trial_ok;

    msb_locator u_msb_rem
    (
        .din (part_rem),
        .pos (rem_pos)
    );

    msb_locator u_msb_div
    (
        .din (b_mag),
        .pos (div_pos)
    );

    // distance between the two leading ones, negative if divisor is larger
    assign shift = {1'b0, rem_pos} - {1'b0, div_pos};

    // trial subtraction of the divisor aligned to the current bit
    assign trial = {1'b0, part_rem} - ({1'b0, b_mag} << cnt[4:0]);
    assign trial_ok = ~trial[XLEN];

    // still busy while the finish strobe is out
    assign idle = (state == S_IDLE) && !fin;

    always_ff @(posedge clk)
    begin
        if (reset || flush2)
        begin
            state <= S_IDLE;
            fin <= 1'b0;
            cnt <= '0;
        end
        else
        begin
            fin <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (start)
                    begin
                        if (div_zero)
                            state <= S_FIX;
                        else
                            state <= S_ALIGN;
                    end
                end
                S_ALIGN:
                begin
                    cnt <= shift;
                    // dividend below divisor, quotient stays 0
                    if (shift[5] || part_rem == '0)
                        state <= S_FIX;
                    else
                        state <= S_ITER;
                end
                S_ITER:
                begin
                    cnt <= cnt - 6'd1;
                    if (cnt == '0)
                        state <= S_FIX;
                end
                S_FIX:
                begin
                    state <= S_IDLE;
                    fin <= 1'b1;
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        case (state)
            S_IDLE:
            begin
                if (start)
                begin
                    part_rem <= a_mag;
                    q <= '0;
                end
            end
            S_ITER:
            begin
                q <= {q[XLEN-2:0], trial_ok};
                if (trial_ok)
                    part_rem <= trial[XLEN-1:0];
            end
            S_FIX:
            begin
                // divide by zero leaves part_rem holding the dividend
                if (div_zero)
                    quo <= '1;
                else
                    quo <= neg_q ? word_t'(-q) : q;
                rem <= neg_r ? word_t'(-part_rem) : part_rem;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/div_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_result
    import div_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        flush2,
    input  wire        fin,
    input  wire        sel_rem,
    input  wire word_t quo,
    input  wire word_t rem,
    output word_t      dout,
    output logic       done
);

    word_t result;

    // remainder subtypes take the remainder
    assign result = sel_rem ? rem : quo;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            dout <= '0;
            done <= 1'b0;
        end
        else if (flush2)
        begin
            // aborted operation, dout keeps the last result
            done <= 1'b0;
        end
        else
        begin
            done <= fin;
            if (fin)
                dout <= result;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/div_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_unit
    import div_pkg::*;
(
    input  wire            clk,
    input  wire            reset,
    input  wire op_class_t op_class,
    input  wire div_op_t   op_sub,
    input  wire word_t     din1,
    input  wire word_t     din2,
    input  wire            stall2,
    input  wire            flush1,
    input  wire            flush2,
    output logic           busy,
    output word_t          dout,
    output logic           done
);

    logic  start;
    word_t a_mag;
    word_t b_mag;
    logic  neg_q;
    logic  neg_r;
    logic  sel_rem;
    logic  div_zero;
    logic  core_idle;
    logic  unit_idle;
    logic  fin;
    word_t quo;
    word_t rem;

    // stall covers the start cycle, the core run and the done cycle
    assign busy = ~core_idle | start | done;
    assign unit_idle = ~busy;

    div_issue u_issue
    (
        .clk       (clk),
        .reset     (reset),
        .flush1    (flush1),
        .flush2    (flush2),
        .stall2    (stall2),
        .core_idle (unit_idle),
        .op_class  (op_class),
        .op_sub    (op_sub),
        .din1      (din1),
        .din2      (din2),
        .start     (start),
        .a_mag     (a_mag),
        .b_mag     (b_mag),
        .neg_q     (neg_q),
        .neg_r     (neg_r),
        .sel_rem   (sel_rem),
        .div_zero  (div_zero)
    );

    div_core u_core
    (
        .clk      (clk),
        .reset    (reset),
        .flush2   (flush2),
        .start    (start),
        .a_mag    (a_mag),
        .b_mag    (b_mag),
        .neg_q    (neg_q),
        .neg_r    (neg_r),
        .div_zero (div_zero),
        .idle     (core_idle),
        .fin      (fin),
        .quo      (quo),
        .rem      (rem)
    );

    div_result u_result
    (
        .clk     (clk),
        .reset   (reset),
        .flush2  (flush2),
        .fin     (fin),
        .sel_rem (sel_rem),
        .quo     (quo),
        .rem     (rem),
        .dout    (dout),
        .done    (done)
    );

endmodule

`default_nettype wire

// ==== bench/div_unit_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_unit_props
    import div_pkg::*;
(
    input wire             clk,
    input wire             reset,
    input wire             flush2,
    input wire             busy,
    input wire             done,
    input wire div_state_t state
);

    // done is a single cycle strobe
    assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done held high for more than one cycle");

    assert property (@(posedge clk) reset |=> !busy && !done && state == S_IDLE)
        else $error("unit not idle after reset");

    // aborted operation returns nothing
    assert property (@(posedge clk) flush2 && !reset |=> !done && !busy)
        else $error("done or busy seen after flush2");

endmodule

bind div_unit div_unit_props u_props
(
    .clk    (clk),
    .reset  (reset),
    .flush2 (flush2),
    .busy   (busy),
    .done   (done),
    .state  (u_core.state)
);

`default_nettype wire

// ==== bench/div_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_unit_tb
    import div_pkg::*;
();

    localparam int CLK_HALF = 50;
    localparam int NUM_RANDOM = 200;
    localparam int NUM_DIRECTED = 30;
    localparam int MAX_LATENCY = 40;
    localparam int WATCHDOG_CYCLES = (NUM_RANDOM + NUM_DIRECTED) * MAX_LATENCY + 2000;

    logic      clk;
    logic      reset;
    op_class_t op_class;
    div_op_t   op_sub;
    word_t     din1;
    word_t     din2;
    logic      stall2;
    logic      flush1;
    logic      flush2;
    logic      busy;
    word_t     dout;
    logic      done;

    word_t lfsr;
    word_t exp_q[$];
    string desc_q[$];
    int    issued = 0;
    int    returned = 0;

    div_unit DUT
    (
        .clk      (clk),
        .reset    (reset),
        .op_class (op_class),
        .op_sub   (op_sub),
        .din1     (din1),
        .din2     (din2),
        .stall2   (stall2),
        .flush1   (flush1),
        .flush2   (flush2),
        .busy     (busy),
        .dout     (dout),
        .done     (done)
    );

    always #CLK_HALF clk = ~clk;

    // right shifting galois form
    function automatic word_t lfsr_next(input word_t s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic word_t take_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            r = {r[XLEN-2:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic word_t ref_div(input div_op_t sub, input word_t a, input word_t b);
        int sa;
        int sb;
        if (b == '0)
            return (sub == DIV_S || sub == DIV_U) ? '1 : a;
        if (sub == DIV_U)
            return a / b;
        if (sub == REM_U)
            return a % b;
        // most negative by minus one
        if (a == 32'h8000_0000 && b == '1)
            return (sub == DIV_S) ? a : '0;
        sa = a;
        sb = b;
        return (sub == DIV_S) ? word_t'(sa / sb) : word_t'(sa % sb);
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp)
            stop_on_error($sformatf("Fail at %0t ns: %s, dout %h, expected %h",
                                    $time, what, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_on_error($sformatf("Fail at %0t ns: %s is %b, expected %b",
                                    $time, what, got, exp));
    endtask

    // results checked mid cycle, in issue order
    always @(negedge clk)
    begin
        if (done)
        begin
            if (exp_q.size() == 0)
                stop_on_error($sformatf("done pulsed at %0t ns with nothing outstanding", $time));
            else
            begin
                check_word(dout, exp_q.pop_front(), desc_q.pop_front());
                returned++;
            end
        end
    end

    initial
    begin
        #(WATCHDOG_CYCLES * 2 * CLK_HALF);
        stop_on_error($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
    end

    task automatic quiet_cycles(input int n, input string what);
        repeat (n)
        begin
            @(negedge clk);
            check_flag(busy, 1'b0, what);
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy)
        begin
            n++;
            if (n > MAX_LATENCY)
                stop_on_error("unit stayed busy and never returned to idle");
            @(negedge clk);
        end
    endtask

    // hold_extra keeps a second request on the inputs while busy
    task automatic run_op(input div_op_t sub, input word_t a, input word_t b, input bit hold_extra);
        int n;
        logic seen;
        wait_idle();
        @(posedge clk);
        op_class <= OP_CLASS_DIV;
        op_sub <= sub;
        din1 <= a;
        din2 <= b;
        exp_q.push_back(ref_div(sub, a, b));
        desc_q.push_back($sformatf("sub %0d a %h b %h", sub, a, b));
        issued++;
        @(posedge clk);
        if (hold_extra)
        begin
            din1 <= ~a;
            din2 <= b ^ 32'd1;
        end
        else
            op_class <= 4'd0;
        seen = 1'b0;
        n = 0;
        while (!seen && n < MAX_LATENCY)
        begin
            @(negedge clk);
            check_flag(busy, 1'b1, "busy while dividing");
            seen = done;
            n++;
            if (!seen)
            begin
                @(posedge clk);
                if (n == 2)
                    op_class <= 4'd0;
            end
        end
        if (!seen)
            stop_on_error($sformatf("no done within %0d cycles of acceptance", MAX_LATENCY));
        @(negedge clk);
        check_flag(busy, 1'b0, "busy after done");
    endtask

    task automatic blocked_op(input bit use_flush);
        wait_idle();
        @(posedge clk);
        op_class <= OP_CLASS_DIV;
        op_sub <= DIV_U;
        din1 <= 32'd100;
        din2 <= 32'd7;
        flush1 <= use_flush;
        stall2 <= !use_flush;
        quiet_cycles(3, use_flush ? "busy under flush1" : "busy under stall2");
        @(posedge clk);
        op_class <= 4'd0;
        flush1 <= 1'b0;
        stall2 <= 1'b0;
        quiet_cycles(8, "busy after blocked request");
    endtask

    task automatic other_classes();
        for (int c = 0; c < 16; c++)
        begin
            if (op_class_t'(c) != OP_CLASS_DIV)
            begin
                @(posedge clk);
                op_class <= op_class_t'(c);
                din1 <= take_bits(32);
                din2 <= take_bits(32);
                @(negedge clk);
                check_flag(busy, 1'b0, "busy on another class");
            end
        end
        @(posedge clk);
        op_class <= 4'd0;
        quiet_cycles(4, "busy on another class");
    endtask

    // long operation aborted partway through the loop
    task automatic abort_op();
        wait_idle();
        @(posedge clk);
        op_class <= OP_CLASS_DIV;
        op_sub <= DIV_U;
        din1 <= '1;
        din2 <= 32'd1;
        @(posedge clk);
        op_class <= 4'd0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_flag(busy, 1'b1, "busy before flush2");
        @(posedge clk);
        flush2 <= 1'b1;
        @(posedge clk);
        flush2 <= 1'b0;
        quiet_cycles(MAX_LATENCY, "busy after flush2");
    endtask

    initial
    begin
        word_t   a;
        word_t   b;
        div_op_t sub;
        clk = 1'b0;
        reset = 1'b1;
        op_class = '0;
        op_sub = '0;
        din1 = '0;
        din2 = '0;
        stall2 = 1'b0;
        flush1 = 1'b0;
        flush2 = 1'b0;
        lfsr = 32'h62b3;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(done, 1'b0, "done after reset");
        check_word(dout, '0, "dout after reset");

        // divide by zero, overflow, small and equal operands
        run_op(DIV_S, 32'd100, 32'd0, 1'b0);
        run_op(REM_S, 32'hffff_fff9, 32'd0, 1'b0);
        run_op(DIV_U, 32'h8765_4321, 32'd0, 1'b1);
        run_op(REM_U, 32'h1234_5678, 32'd0, 1'b0);
        run_op(DIV_S, 32'h8000_0000, 32'hffff_ffff, 1'b0);
        run_op(REM_S, 32'h8000_0000, 32'hffff_ffff, 1'b0);
        run_op(DIV_U, 32'h8000_0000, 32'hffff_ffff, 1'b0);
        run_op(DIV_S, 32'd5, 32'd7, 1'b0);
        run_op(REM_U, 32'd5, 32'd7, 1'b0);
        run_op(DIV_S, 32'hffff_fff9, 32'd2, 1'b1);
        run_op(REM_S, 32'hffff_fff9, 32'd2, 1'b0);
        run_op(DIV_U, 32'hdead_beef, 32'hdead_beef, 1'b0);
        run_op(REM_S, 32'hffff_fffb, 32'hffff_fffb, 1'b0);
        run_op(DIV_U, 32'hffff_ffff, 32'd1, 1'b1);
        run_op(DIV_S, 32'd0, 32'd5, 1'b0);

        blocked_op(1'b1);
        blocked_op(1'b0);
        other_classes();
        abort_op();
        run_op(DIV_S, 32'd1000, 32'hffff_fffd, 1'b0);

        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            sub = div_op_t'(take_bits(2));
            a = take_bits(32) >> take_bits(5);
            b = take_bits(32) >> take_bits(5);
            if (take_bits(1) != 0)
                a = ~a;
            if (take_bits(1) != 0)
                b = ~b;
            if (take_bits(4) == 0)
                b = '0;
            run_op(sub, a, b, take_bits(1) != 0);
        end

        quiet_cycles(4, "busy after last operation");
        if (exp_q.size() == 0 && returned == issued)
        begin
            $display("Test passed");
            $finish;
        end
        else
            stop_on_error($sformatf("%0d operations issued but %0d results returned",
                                    issued, returned));
    end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/div_pkg.sv
verilog/msb_locator.sv
verilog/div_issue.sv
verilog/div_core.sv
verilog/div_result.sv
verilog/div_unit.sv
bench/div_unit_props.sv
bench/div_unit_tb.sv
